// File: logic/spim_cfg_pkg.sv
/*
  SPI master transmit configuration
  Lane modes, transfer controller states and the
  default sizes used by the transmit subsystem top level
*/
package spim_cfg_pkg;

  ////////////////////
  // Encodings
  ////////////////////

  // Lane mode of one transfer
  typedef enum logic [0:0] {
    LANE_SINGLE = 1'b0,  // One bit per serial clock on lane 0
    LANE_QUAD   = 1'b1   // One nibble per serial clock on lanes 3 to 0
  } lane_mode_e;

  // Transfer controller states
  typedef enum logic [1:0] {
    CTRL_IDLE  = 2'd0,  // Chip select high
    CTRL_SETUP = 2'd1,  // Chip select low and command settling
    CTRL_SHIFT = 2'd2,  // Shifter enabled
    CTRL_HOLD  = 2'd3   // Chip select hold after the last edge
  } ctrl_state_e;

  ////////////////////
  // Defaults
  ////////////////////

  localparam int FIFO_DEPTH_DEF = 8;  // Transmit FIFO words
  localparam int CLK_DIV_DEF    = 4;  // System clocks per serial clock, even and >= 2

endpackage

// File: logic/spim_bus_pkg.sv
/*
  SPI master transmit bus types
  Start command and pad bundle shared between the
  top level and the transfer controller
*/
package spim_bus_pkg;

  // Start command issued by the host with start_i
  typedef struct packed {
    spim_cfg_pkg::lane_mode_e mode;       // Single or quad lanes
    logic [15:0]              bit_count;  // Total bits, multiple of 4 in quad
  } spim_cmd_t;

  // Registered pad bundle
  typedef struct packed {
    logic       csn;   // Chip select, active low
    logic       sclk;  // Serial clock, idles low
    logic [3:0] sdo;   // Data lanes with lane 0 in bit 0
  } spim_pad_t;

endpackage

// File: logic/spim_txfifo.sv
/*
  SPI master transmit word FIFO
  Circular buffer fed by a host push strobe and drained by
  the shifter accept pulse. A push into a full FIFO is dropped
  and sets a sticky overflow flag
*/
`timescale 1ns/1ns

module spim_txfifo #(
  parameter int DEPTH = 8
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        flush_i,     // Empty the FIFO
  input  logic        push_i,      // Host write strobe
  input  logic [31:0] wdata_i,
  input  logic        pop_i,       // Shifter accept
  output logic [31:0] rdata_o,     // Head word
  output logic        valid_o,     // Not empty
  output logic        overflow_o,  // Sticky dropped push
  input  logic        clr_ovf_i    // Clear on transfer start
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [31:0]   mem [DEPTH];  // Word storage
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;        // Occupancy
  logic          full;
  logic          wr_en;
  logic          rd_en;

  // Pointer advance with wrap for any depth
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == CW'(DEPTH));
  assign valid_o = (count != '0);
  assign wr_en   = push_i & ~full;   // Drop when full
  assign rd_en   = pop_i & valid_o;
  assign rdata_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= wdata_i;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (flush_i) begin                     // Flush wins over push and pop
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
        if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
        case ({wr_en, rd_en})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;          // Idle or push and pop together
        endcase
      end
      // Overflow stays set until the next start
      if (push_i && full) overflow_o <= 1'b1;
      else if (clr_ovf_i) overflow_o <= 1'b0;
    end
  end

endmodule

// File: logic/spim_clkgen.sv
/*
  SPI serial clock generator
  Divides the system clock while run_i is high and marks
  every falling serial clock edge with a one cycle pulse.
  A first pulse right after run_i rises sets up lane data
*/
`timescale 1ns/1ns

module spim_clkgen #(
  parameter int CLK_DIV = 4
) (
  input  logic clk,
  input  logic rstn,
  input  logic run_i,      // Clock request from the shifter
  output logic sclk_o,     // Serial clock, parked low
  output logic tx_edge_o   // Lane update strobe
);

  localparam int HALF = CLK_DIV / 2;                     // Clocks per half period
  localparam int CW   = (HALF > 1) ? $clog2(HALF) : 1;

  logic [CW-1:0] half_cnt;  // Position inside the half period
  logic          run_q;     // run_i one cycle late
  logic          half_end;  // Last clock of the half period

  assign half_end = (half_cnt == CW'(HALF - 1));

  // Setup pulse on run rise, then one pulse per falling edge
  assign tx_edge_o = run_i & (~run_q | (sclk_o & half_end));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      half_cnt <= '0;
      sclk_o   <= 1'b0;
      run_q    <= 1'b0;
    end else begin
      run_q <= run_i;
      if (!run_i) begin
        half_cnt <= '0;           // Stopped
        sclk_o   <= 1'b0;         // Park low
      end else if (half_end) begin
        half_cnt <= '0;
        sclk_o   <= ~sclk_o;      // Toggle every half period
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

endmodule

// File: logic/spim_tx.sv
/*
  SPI master word shifter
  Loads 32 bit words from the FIFO and shifts them out MSB first
  on one or four lanes at each transmit edge. Words are chained
  until the lane cycle target of the command is reached. An empty
  FIFO pauses the transfer with the clock parked
*/
`timescale 1ns/1ns

module spim_tx (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     flush_i,        // Abort
  input  logic                     en_i,           // Controller shifting
  input  logic                     tx_edge_i,      // Falling edge strobe
  input  spim_cfg_pkg::lane_mode_e mode_i,
  input  logic [15:0]              bit_count_i,
  input  logic [31:0]              word_i,         // FIFO head
  input  logic                     word_valid_i,
  output logic                     word_accept_o,  // One pulse per loaded word
  output logic                     done_o,         // Last lane cycle on the pads
  output logic [3:0]               sdo_o,
  output logic                     clk_req_o       // Run the clock generator
);

  typedef enum logic [0:0] {
    TX_IDLE = 1'b0,
    TX_SEND = 1'b1
  } tx_state_e;

  localparam logic [3:0] SDO_IDLE = 4'b1100;  // Lanes 2 and 3 high for WP and HOLD

  tx_state_e   tx_cs;
  tx_state_e   tx_ns;        // State after the next transmit edge
  logic [31:0] data_q;       // Word being shifted
  logic [31:0] data_nx;
  logic [15:0] lane_cnt;     // Lane cycle now on the pads
  logic [15:0] lane_cnt_nx;
  logic [15:0] target;       // Lane cycles in the command
  logic        quad;
  logic        last_lane;
  logic        word_end;     // Last lane cycle of the current word
  logic        idle_q;       // Idle for at least one full cycle
  logic        start_ok;
  logic        req;          // Word load request
  logic        load;
  logic        accept_q;

  // Lane values for a word in the given mode
  function automatic logic [3:0] lane_bits(input logic q, input logic [31:0] d);
    return q ? d[31:28] : {2'b11, 1'b0, d[31]};
  endfunction

  ////////////////////
  // Counting
  ////////////////////

  assign quad      = (mode_i == spim_cfg_pkg::LANE_QUAD);
  assign target    = quad ? {2'b00, bit_count_i[15:2]} : bit_count_i;  // Bits or nibbles
  assign last_lane = ((lane_cnt + 16'd1) == target);
  assign word_end  = quad ? (lane_cnt[2:0] == 3'b111) : (lane_cnt[4:0] == 5'b11111);
  assign done_o    = (tx_cs == TX_SEND) & last_lane;

  // Restart only after a full idle cycle so the clock generator sees run drop
  assign start_ok  = en_i & word_valid_i & idle_q;
  assign clk_req_o = ~flush_i & ((tx_cs == TX_SEND) | start_ok);

  assign load          = req & tx_edge_i;
  assign word_accept_o = accept_q;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    tx_ns       = tx_cs;
    data_nx     = data_q;
    lane_cnt_nx = lane_cnt;
    req         = 1'b0;
    case (tx_cs)
      TX_IDLE: begin
        if (start_ok) begin             // Fresh start or resume after a pause
          req     = 1'b1;
          data_nx = word_i;
          tx_ns   = TX_SEND;
        end
      end
      TX_SEND: begin
        if (last_lane) begin            // Command complete
          lane_cnt_nx = '0;
          tx_ns       = TX_IDLE;
        end else if (word_end) begin
          lane_cnt_nx = lane_cnt + 16'd1;
          if (en_i && word_valid_i) begin
            req     = 1'b1;             // Chain next word
            data_nx = word_i;
          end else begin
            tx_ns = TX_IDLE;            // FIFO empty so pause
          end
        end else begin
          lane_cnt_nx = lane_cnt + 16'd1;
          data_nx     = quad ? {data_q[27:0], 4'h0} : {data_q[30:0], 1'b0};
        end
      end
      default: tx_ns = TX_IDLE;
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (tx_edge_i) data_q <= data_nx;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      tx_cs    <= TX_IDLE;
      lane_cnt <= '0;
      idle_q   <= 1'b1;
      accept_q <= 1'b0;
      sdo_o    <= SDO_IDLE;
    end else if (flush_i) begin
      tx_cs    <= TX_IDLE;
      lane_cnt <= '0;
      idle_q   <= 1'b1;
      accept_q <= 1'b0;
      sdo_o    <= SDO_IDLE;
    end else begin
      idle_q   <= (tx_cs == TX_IDLE);
      accept_q <= load;                 // Pop after the load edge
      if (tx_edge_i) begin
        tx_cs    <= tx_ns;
        lane_cnt <= lane_cnt_nx;
        // Lanes change on the falling edge only
        sdo_o    <= (tx_ns == TX_SEND) ? lane_bits(quad, data_nx) : SDO_IDLE;
      end else if (!en_i && tx_cs == TX_IDLE) begin
        lane_cnt <= '0;                 // Ready for the next command
      end
    end
  end

endmodule

// File: logic/spim_ctrl.sv
/*
  SPI master transfer controller
  Registers the start command, drops chip select for the
  transfer, enables the shifter and holds chip select for a
  half serial period after the last edge. Abort ends at once
*/
`timescale 1ns/1ns

module spim_ctrl #(
  parameter int CLK_DIV = 4
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     start_i,
  input  spim_bus_pkg::spim_cmd_t  cmd_i,
  input  logic                     abort_i,
  input  logic                     shift_done_i,  // Last lane cycle on the pads
  input  logic                     tx_edge_i,
  input  logic [3:0]               sdo_i,
  input  logic                     sclk_i,
  output logic                     tx_en_o,
  output logic                     flush_o,
  output spim_cfg_pkg::lane_mode_e mode_o,
  output logic [15:0]              bit_count_o,
  output logic                     clr_ovf_o,
  output spim_bus_pkg::spim_pad_t  pad_o,
  output logic                     busy_o,
  output logic                     done_o
);

  localparam int HALF = CLK_DIV / 2;
  localparam int HW   = $clog2(HALF + 1);

  spim_cfg_pkg::ctrl_state_e state_q;
  spim_cfg_pkg::ctrl_state_e state_d;
  spim_bus_pkg::spim_cmd_t   cmd_q;      // Command of the running transfer
  logic [HW-1:0]             hold_cnt;
  logic                      hold_end;
  logic                      start_ok;

  assign start_ok    = start_i & ~abort_i & (state_q == spim_cfg_pkg::CTRL_IDLE);
  assign hold_end    = (hold_cnt == HW'(HALF));  // Pad sclk is one stage behind csn
  assign tx_en_o     = (state_q == spim_cfg_pkg::CTRL_SHIFT);
  assign busy_o      = (state_q != spim_cfg_pkg::CTRL_IDLE);
  assign flush_o     = abort_i;                   // Flush FIFO and shifter together
  assign clr_ovf_o   = start_ok;
  assign mode_o      = cmd_q.mode;
  assign bit_count_o = cmd_q.bit_count;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    if (abort_i) begin
      state_d = spim_cfg_pkg::CTRL_IDLE;
    end else begin
      case (state_q)
        spim_cfg_pkg::CTRL_IDLE:  if (start_i) state_d = spim_cfg_pkg::CTRL_SETUP;
        spim_cfg_pkg::CTRL_SETUP: state_d = spim_cfg_pkg::CTRL_SHIFT;
        spim_cfg_pkg::CTRL_SHIFT: begin
          if (shift_done_i && tx_edge_i) state_d = spim_cfg_pkg::CTRL_HOLD;  // Final edge
        end
        spim_cfg_pkg::CTRL_HOLD:  if (hold_end) state_d = spim_cfg_pkg::CTRL_IDLE;
        default:                  state_d = spim_cfg_pkg::CTRL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q  <= spim_cfg_pkg::CTRL_IDLE;
      cmd_q    <= '0;
      hold_cnt <= '0;
      done_o   <= 1'b0;
      pad_o    <= '{csn: 1'b1, sclk: 1'b0, sdo: 4'b1100};
    end else begin
      state_q <= state_d;
      if (start_ok) cmd_q <= cmd_i;
      if (state_q == spim_cfg_pkg::CTRL_HOLD) hold_cnt <= hold_cnt + 1'b1;
      else hold_cnt <= '0;
      // Done together with csn rising
      done_o     <= ~abort_i & hold_end & (state_q == spim_cfg_pkg::CTRL_HOLD);
      pad_o.csn  <= (state_d == spim_cfg_pkg::CTRL_IDLE);
      pad_o.sclk <= sclk_i;
      pad_o.sdo  <= sdo_i;
    end
  end

endmodule

// File: logic/spim_tx_top.sv
/*
  SPI master transmit subsystem
  Host words enter the FIFO and a start command sends them
  MSB first on one or four lanes under chip select
*/
`timescale 1ns/1ns

module spim_tx_top #(
  parameter int FIFO_DEPTH = spim_cfg_pkg::FIFO_DEPTH_DEF,
  parameter int CLK_DIV    = spim_cfg_pkg::CLK_DIV_DEF
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    push_i,      // Word write strobe
  input  logic [31:0]             wdata_i,
  input  logic                    start_i,     // Command strobe
  input  spim_bus_pkg::spim_cmd_t cmd_i,
  input  logic                    abort_i,
  output spim_bus_pkg::spim_pad_t pad_o,
  output logic                    busy_o,
  output logic                    done_o,
  output logic                    overflow_o
);

  logic [31:0]              word;         // FIFO head
  logic                     word_valid;
  logic                     word_accept;
  logic                     flush;
  logic                     clr_ovf;
  logic                     tx_en;
  logic                     clk_req;
  logic                     tx_edge;
  logic                     sclk;
  logic                     shift_done;
  logic [3:0]               sdo;
  spim_cfg_pkg::lane_mode_e mode;
  logic [15:0]              bit_count;

  ////////////////////
  // Input side
  ////////////////////

  spim_txfifo #(
    .DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .clk        (clk),
    .rstn       (rstn),
    .flush_i    (flush),
    .push_i     (push_i),
    .wdata_i    (wdata_i),
    .pop_i      (word_accept),
    .rdata_o    (word),
    .valid_o    (word_valid),
    .overflow_o (overflow_o),
    .clr_ovf_i  (clr_ovf)
  );

  ////////////////////
  // Processing
  ////////////////////

  spim_clkgen #(
    .CLK_DIV (CLK_DIV)
  ) i_clkgen (
    .clk       (clk),
    .rstn      (rstn),
    .run_i     (clk_req),
    .sclk_o    (sclk),
    .tx_edge_o (tx_edge)
  );

  spim_tx i_tx (
    .clk           (clk),
    .rstn          (rstn),
    .flush_i       (flush),
    .en_i          (tx_en),
    .tx_edge_i     (tx_edge),
    .mode_i        (mode),
    .bit_count_i   (bit_count),
    .word_i        (word),
    .word_valid_i  (word_valid),
    .word_accept_o (word_accept),
    .done_o        (shift_done),
    .sdo_o         (sdo),
    .clk_req_o     (clk_req)
  );

  ////////////////////
  // Output side
  ////////////////////

  spim_ctrl #(
    .CLK_DIV (CLK_DIV)
  ) i_ctrl (
    .clk          (clk),
    .rstn         (rstn),
    .start_i      (start_i),
    .cmd_i        (cmd_i),
    .abort_i      (abort_i),
    .shift_done_i (shift_done),
    .tx_edge_i    (tx_edge),
    .sdo_i        (sdo),
    .sclk_i       (sclk),
    .tx_en_o      (tx_en),
    .flush_o      (flush),
    .mode_o       (mode),
    .bit_count_o  (bit_count),
    .clr_ovf_o    (clr_ovf),
    .pad_o        (pad_o),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

endmodule

// File: sim/tb_clk_gen.sv
/*
  Testbench clock and reset source
  Free running clock with an active low reset held for a few cycles
*/
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD       = 10,  // ns
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rstn_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rstn_o = 1'b1;  // Release just after the edge
  end

endmodule

// File: sim/spim_tx_tb.sv
/*
  SPI master transmit testbench
  Directed tests push words, start a command and wait for done.
  A lane monitor rebuilds the sent bits on every serial clock
  rise under chip select and compares them with the pushed words
*/
`timescale 1ns/1ns

module spim_tx_tb;

  localparam int          CLK_DIV    = 4;
  localparam int          FIFO_DEPTH = 8;
  localparam int          MARGIN     = 60;     // Setup, clock start and csn hold
  localparam int          MAX_CYCLES = 20000;  // About ten times the summed test lengths
  localparam int unsigned SEED       = 32'h3f345bae;

  logic                    clk;
  logic                    rstn;
  logic                    push;
  logic [31:0]             wdata;
  logic                    start;
  spim_bus_pkg::spim_cmd_t cmd;
  logic                    abort;
  spim_bus_pkg::spim_pad_t pad;
  logic                    busy;
  logic                    done;
  logic                    overflow;

  int unsigned              cycles = 0;
  int                       errors = 0;      // All tests
  int                       test_errs = 0;   // Current test
  int                       tests_run = 0;
  int                       tests_failed = 0;
  spim_cfg_pkg::lane_mode_e mon_mode = spim_cfg_pkg::LANE_SINGLE;
  logic                     cap_bits[$];     // Bits seen on the lanes in send order
  logic [31:0]              words[$];        // Words expected in send order
  int                       rise_cnt = 0;    // sclk rises under csn
  int                       done_cnt = 0;
  logic                     sclk_q = 1'b0;

  tb_clk_gen #(
    .PERIOD       (10),
    .RESET_CYCLES (5)
  ) i_clk_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  spim_tx_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CLK_DIV    (CLK_DIV)
  ) i_dut (
    .clk        (clk),
    .rstn       (rstn),
    .push_i     (push),
    .wdata_i    (wdata),
    .start_i    (start),
    .cmd_i      (cmd),
    .abort_i    (abort),
    .pad_o      (pad),
    .busy_o     (busy),
    .done_o     (done),
    .overflow_o (overflow)
  );

  ////////////////////
  // Monitors
  ////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Pads are sampled mid cycle where they are settled
  always @(negedge clk) begin
    if (rstn) begin
      if (!pad.csn && pad.sclk && !sclk_q) begin  // Serial clock rise
        rise_cnt++;
        if (mon_mode == spim_cfg_pkg::LANE_QUAD) begin
          for (int i = 3; i >= 0; i--) cap_bits.push_back(pad.sdo[i]);  // Lane 3 is MSB
        end else begin
          cap_bits.push_back(pad.sdo[0]);
        end
      end
      sclk_q = pad.sclk;
      if (done) done_cnt++;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic int limit_for(input int lanes);
    return lanes * CLK_DIV + MARGIN;  // One serial period per lane cycle
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    test_errs++;
  endtask

  task automatic push_word(input logic [31:0] w);
    @(posedge clk);
    #1;
    push  = 1'b1;
    wdata = w;
    @(posedge clk);
    #1;
    push  = 1'b0;
  endtask

  task automatic start_cmd(input spim_cfg_pkg::lane_mode_e m, input logic [15:0] bits);
    @(posedge clk);
    #1;
    mon_mode = m;
    cap_bits.delete();  // Fresh capture per transfer
    rise_cnt      = 0;
    cmd.mode      = m;
    cmd.bit_count = bits;
    start         = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int  n;
    bit  seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      @(negedge clk);
      if (done) seen = 1'b1;
      n++;
    end
    if (!seen) begin
      $display("Transfer did not end within %0d cycles at %0t ns", limit, $time);
      test_errs++;
    end else if (pad.csn !== 1'b1) begin
      report_error("csn still low when done_o pulsed");
    end
  endtask

  // Capture bit i maps to bit (31 - i % 32) of word (i / 32)
  task automatic check_bits(input int nbits);
    logic exp;
    if (cap_bits.size() != nbits) begin
      report_error($sformatf("captured %0d bits, expected %0d", cap_bits.size(), nbits));
    end else begin
      for (int i = 0; i < nbits; i++) begin
        exp = words[i / 32][31 - (i % 32)];
        if (cap_bits[i] !== exp) begin
          report_error($sformatf("bit %0d is %b, expected %b", i, cap_bits[i], exp));
          break;
        end
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: failed with %0d errors", name, test_errs);
      tests_failed++;
    end
    errors   += test_errs;
    test_errs = 0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_state();
    if (pad.csn !== 1'b1 || pad.sclk !== 1'b0 || pad.sdo !== 4'b1100)
      report_error($sformatf("pad after reset csn %b sclk %b sdo %b", pad.csn, pad.sclk,
                             pad.sdo));
    if (busy !== 1'b0 || done !== 1'b0 || overflow !== 1'b0)
      report_error("busy, done or overflow high after reset");
    end_test("reset state");
  endtask

  task automatic test_single_word();
    words.delete();
    words.push_back($urandom());
    push_word(words[0]);
    start_cmd(spim_cfg_pkg::LANE_SINGLE, 16'd32);
    wait_done(limit_for(32));
    check_bits(32);
    end_test("single lane 32 bits");
  endtask

  task automatic test_quad_two_words();
    words.delete();
    repeat (2) words.push_back($urandom());
    push_word(words[0]);
    push_word(words[1]);
    start_cmd(spim_cfg_pkg::LANE_QUAD, 16'd64);
    wait_done(limit_for(16));  // 16 nibbles
    check_bits(64);
    end_test("quad lane 64 bits");
  endtask

  task automatic test_short_single();
    words.delete();
    words.push_back($urandom());
    push_word(words[0]);
    start_cmd(spim_cfg_pkg::LANE_SINGLE, 16'd8);
    wait_done(limit_for(8));
    check_bits(8);  // Top byte only
    if (rise_cnt != 8) report_error($sformatf("%0d sclk rises, expected 8", rise_cnt));
    end_test("single lane 8 bits");
  endtask

  task automatic test_overflow();
    words.delete();
    for (int i = 0; i < 9; i++) begin
      words.push_back($urandom());
      push_word(words[i]);
      if (i == 7 && overflow !== 1'b0) report_error("overflow high with FIFO just full");
    end
    if (overflow !== 1'b1) report_error("overflow low after push into full FIFO");
    void'(words.pop_back());  // Ninth word was dropped
    start_cmd(spim_cfg_pkg::LANE_SINGLE, 16'd256);
    if (overflow !== 1'b0) report_error("overflow not cleared by start");
    wait_done(limit_for(256));
    check_bits(256);
    end_test("overflow and 256 bits");
  endtask

  task automatic test_abort();
    int n;
    int done_before;
    n = 0;
    repeat (FIFO_DEPTH) push_word($urandom());
    start_cmd(spim_cfg_pkg::LANE_SINGLE, 16'd256);
    while (cap_bits.size() < 40 && n < limit_for(40)) begin  // Get well into the transfer
      @(posedge clk);
      n++;
    end
    if (cap_bits.size() < 40) begin
      $display("Transfer before abort stalled at %0d bits", cap_bits.size());
      test_errs++;
    end
    done_before = done_cnt;
    @(posedge clk);
    #1;
    abort = 1'b1;
    @(posedge clk);
    #1;
    abort = 1'b0;
    if (pad.csn !== 1'b1 || busy !== 1'b0) report_error("csn low or busy high after abort");
    repeat (40) @(posedge clk);
    if (done_cnt != done_before) report_error("done_o pulsed after abort");
    // Fresh word must come out first if the FIFO was flushed
    words.delete();
    words.push_back($urandom());
    push_word(words[0]);
    start_cmd(spim_cfg_pkg::LANE_SINGLE, 16'd32);
    wait_done(limit_for(32));
    check_bits(32);
    end_test("abort and flush");
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    void'($urandom(SEED));  // Seed the generator once
    push     = 1'b0;
    wdata    = '0;
    start    = 1'b0;
    cmd      = '0;
    abort    = 1'b0;
    wait (rstn === 1'b1);
    @(posedge clk);
    #1;
    test_reset_state();
    test_single_word();
    test_quad_two_words();
    test_short_single();
    test_overflow();
    test_abort();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: filelist.f
logic/spim_cfg_pkg.sv
logic/spim_bus_pkg.sv
logic/spim_txfifo.sv
logic/spim_clkgen.sv
logic/spim_tx.sv
logic/spim_ctrl.sv
logic/spim_tx_top.sv
sim/tb_clk_gen.sv
sim/spim_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the SPI master transmit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f filelist.f \
     --top-module spim_tx_tb -o spim_tx_sim; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/spim_tx_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
  exit 0
fi
echo "Simulation did not report success"
exit 1
